//--- logic/spmv_consts.svh
`ifndef SPMV_CONSTS_SVH
`define SPMV_CONSTS_SVH

// ******************************
// widths
// ******************************
`define DATA_W     64
`define INST_W     32
`define AEG_IDX_W  18
`define CAEP_W     5
`define OP_W       3
`define PE_ID_W    5

// aeg file
`define AEG_CNT    2

// instruction class, top four instruction bits
`define CLASS_AEG_WR  4'd1
`define CLASS_AEG_RD  4'd2
`define CLASS_CUSTOM  4'd3

// ******************************
// processing element opcodes
// ******************************
`define OP_NOP     3'd0
`define OP_FETCH   3'd1
`define OP_ACCUM   3'd2
`define OP_RESULT  3'd3

// stage chain
`define PE_COUNT   4
// guaranteed busy cycles after a send
`define MIN_BUSY   32

`endif

//--- logic/spmv_pkg.sv
`include "spmv_consts.svh"

package spmv_pkg;

   // ******************************
   // words on the stage chain
   // ******************************

   // command view, as seen by the stages
   typedef struct packed {
      logic [`DATA_W-`PE_ID_W-`OP_W-1:0] payload;
      logic [`PE_ID_W-1:0]               pe_id;
      logic [`OP_W-1:0]                  opcode;
   } pe_cmd_t;

   // result view, as captured into aeg 0
   typedef struct packed {
      logic [`DATA_W-`OP_W-1:0] value;
      logic [`OP_W-1:0]         opcode;
   } pe_result_t;

   // opcode lands in the same low bits in both views
   typedef union packed {
      pe_cmd_t    cmd;
      pe_result_t result;
   } pe_word_u;

endpackage

//--- logic/dispatch_decode.sv
`timescale 1ns/1ps

`include "spmv_consts.svh"

module dispatch_decode (
   input  logic                  clk,
   input  logic                  reset_per,
   input  logic [`INST_W-1:0]    cae_inst_i,
   input  logic                  cae_inst_vld_i,
   output logic                  aeg_wr_o,
   output logic                  aeg_rd_o,
   output logic [`AEG_IDX_W-1:0] aeg_idx_o,
   output logic                  idx_ok_o,
   output logic                  launch_o,
   output logic [1:0]            cae_exception_o
);

   localparam int CLASS_W = 4;
   localparam logic [`AEG_IDX_W-1:0] AEG_LIMIT = `AEG_CNT;
   localparam logic [`CAEP_W-1:0] CAEP_NOOP = 0;
   localparam logic [`CAEP_W-1:0] CAEP_LAUNCH = 1;

   logic [CLASS_W-1:0] inst_class;
   logic [`CAEP_W-1:0] inst_caep;
   logic               class_known;
   logic               caep_known;
   logic               is_custom;
   logic               err_unimpl;
   logic               err_aegidx;
   logic               err_unimpl_q;
   logic               err_aegidx_q;

   // field split
   assign inst_class = cae_inst_i[`INST_W-1 -: CLASS_W];
   assign inst_caep  = cae_inst_i[`AEG_IDX_W +: `CAEP_W];
   assign aeg_idx_o  = cae_inst_i[`AEG_IDX_W-1:0];
   assign idx_ok_o   = aeg_idx_o < AEG_LIMIT;

   assign aeg_wr_o  = cae_inst_vld_i && (inst_class == `CLASS_AEG_WR);
   assign aeg_rd_o  = cae_inst_vld_i && (inst_class == `CLASS_AEG_RD);
   assign is_custom = cae_inst_vld_i && (inst_class == `CLASS_CUSTOM);

   // custom 0 is accepted and ignored, custom 1 starts the chain
   assign launch_o = is_custom && (inst_caep == CAEP_LAUNCH);

   assign class_known = (inst_class == `CLASS_AEG_WR) || (inst_class == `CLASS_AEG_RD)
                        || (inst_class == `CLASS_CUSTOM);
   assign caep_known  = (inst_caep == CAEP_NOOP) || (inst_caep == CAEP_LAUNCH);

   assign err_unimpl = cae_inst_vld_i && (!class_known || (is_custom && !caep_known));
   assign err_aegidx = (aeg_wr_o || aeg_rd_o) && !idx_ok_o;

   // flags live for one cycle after the instruction
   always_ff @(posedge clk) begin
      if (reset_per) begin
         err_unimpl_q <= 1'b0;
         err_aegidx_q <= 1'b0;
      end else begin
         err_unimpl_q <= err_unimpl;
         err_aegidx_q <= err_aegidx;
      end
   end

   assign cae_exception_o = {err_aegidx_q, err_unimpl_q};

endmodule

//--- logic/launch_ctrl.sv
`timescale 1ns/1ps

`include "spmv_consts.svh"

module launch_ctrl (
   input  logic              clk,
   input  logic              reset_per,
   input  logic              launch_i,
   input  spmv_pkg::pe_word_u aeg0_i,
   input  logic              chain_busy_i,
   output spmv_pkg::pe_word_u word_o,
   output logic              cae_idle_o,
   output logic              cae_stall_o
);

   import spmv_pkg::*;

   localparam int CNT_W = $clog2(`MIN_BUSY + 1);
   localparam logic [CNT_W-1:0] BUSY_LOAD = `MIN_BUSY;
   localparam pe_word_u NOP_WORD = pe_word_u'({{(`DATA_W-`OP_W){1'b0}}, `OP_NOP});

   logic             send_q;
   pe_word_u         word_q;
   logic [CNT_W-1:0] busy_cnt_q;
   logic             busy_cnt_act;

   // ******************************
   // send pulse and issued word
   // ******************************
   always_ff @(posedge clk) begin
      if (reset_per) begin
         send_q <= 1'b0;
         word_q <= NOP_WORD;
      end else begin
         send_q <= launch_i;
         word_q <= send_q ? aeg0_i : NOP_WORD;
      end
   end

   assign word_o = word_q;

   // minimum busy window counting down from the send pulse
   always_ff @(posedge clk) begin
      if (reset_per) begin
         busy_cnt_q <= '0;
      end else if (send_q) begin
         busy_cnt_q <= BUSY_LOAD;
      end else if (busy_cnt_act) begin
         busy_cnt_q <= busy_cnt_q - 1'b1;
      end
   end

   assign busy_cnt_act = busy_cnt_q != '0;

   assign cae_stall_o = launch_i || send_q || busy_cnt_act || chain_busy_i;
   assign cae_idle_o  = !cae_stall_o;

endmodule

//--- logic/pe_stage.sv
`timescale 1ns/1ps

`include "spmv_consts.svh"

module pe_stage #(
   parameter int unsigned PE_ID = 0
) (
   input  logic              clk,
   input  logic              reset_per,
   input  spmv_pkg::pe_word_u word_i,
   input  logic              busy_i,
   output spmv_pkg::pe_word_u word_o,
   output logic              busy_o
);

   import spmv_pkg::*;

   localparam int PAYLOAD_W = `DATA_W - `PE_ID_W - `OP_W;
   localparam logic [`PE_ID_W-1:0] MY_ID = PE_ID[`PE_ID_W-1:0];
   localparam pe_word_u NOP_WORD = pe_word_u'({{(`DATA_W-`OP_W){1'b0}}, `OP_NOP});

   logic [PAYLOAD_W-1:0] acc_q;
   logic [PAYLOAD_W-1:0] acc_d;
   pe_word_u             word_q;
   pe_word_u             word_d;
   logic                 hit;

   assign hit = word_i.cmd.pe_id == MY_ID;

   // ******************************
   // command handling
   // ******************************
   always_comb begin
      acc_d  = acc_q;
      word_d = word_i;
      if (hit && (word_i.cmd.opcode == `OP_ACCUM)) begin
         // wraps at payload width
         acc_d  = acc_q + word_i.cmd.payload;
         word_d = NOP_WORD;
      end else if (hit && (word_i.cmd.opcode == `OP_FETCH)) begin
         acc_d                = '0;
         word_d.result.value  = {{`PE_ID_W{1'b0}}, acc_q};
         word_d.result.opcode = `OP_RESULT;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_per) begin
         acc_q  <= '0;
         word_q <= NOP_WORD;
      end else begin
         acc_q  <= acc_d;
         word_q <= word_d;
      end
   end

   assign word_o = word_q;

   // busy ripples down the chain
   assign busy_o = busy_i || (word_q.cmd.opcode != `OP_NOP);

endmodule

//--- logic/aeg_file.sv
`timescale 1ns/1ps

`include "spmv_consts.svh"

module aeg_file (
   input  logic                  clk,
   input  logic                  reset_per,
   input  logic                  aeg_wr_i,
   input  logic                  aeg_rd_i,
   input  logic [`AEG_IDX_W-1:0] aeg_idx_i,
   input  logic                  idx_ok_i,
   input  logic [`DATA_W-1:0]    wr_data_i,
   input  spmv_pkg::pe_word_u    result_i,
   output spmv_pkg::pe_word_u    aeg0_o,
   output logic [`DATA_W-1:0]    ret_data_o,
   output logic                  ret_data_vld_o
);

   localparam int SEL_W = $clog2(`AEG_CNT);

   logic [`DATA_W-1:0] aeg_q [`AEG_CNT];
   logic [SEL_W-1:0]   sel;
   logic               host_wr;
   logic               result_hit;
   logic [`DATA_W-1:0] ret_data_q;
   logic               ret_vld_q;

   assign sel        = aeg_idx_i[SEL_W-1:0];
   assign host_wr    = aeg_wr_i && idx_ok_i;
   assign result_hit = result_i.result.opcode == `OP_RESULT;

   // ******************************
   // register file
   // ******************************
   always_ff @(posedge clk) begin
      if (reset_per) begin
         for (int i = 0; i < `AEG_CNT; i++) begin
            aeg_q[i] <= '0;
         end
      end else begin
         if (result_hit) begin
            aeg_q[0] <= result_i;
         end
         // host write overrides a result in the same cycle
         if (host_wr) begin
            aeg_q[sel] <= wr_data_i;
         end
      end
   end

   assign aeg0_o = aeg_q[0];

   // read return, one cycle after the read
   always_ff @(posedge clk) begin
      if (reset_per) begin
         ret_vld_q <= 1'b0;
      end else begin
         ret_vld_q <= aeg_rd_i && idx_ok_i;
      end
   end

   always_ff @(posedge clk) begin
      if (aeg_rd_i) begin
         ret_data_q <= aeg_q[sel];
      end
   end

   assign ret_data_o     = ret_data_q;
   assign ret_data_vld_o = ret_vld_q;

endmodule

//--- logic/spmv_pers_top.sv
`timescale 1ns/1ps

`include "spmv_consts.svh"

module spmv_pers_top (
   input  logic               clk,
   input  logic               reset_per,
   input  logic [`INST_W-1:0] cae_inst_i,
   input  logic [`DATA_W-1:0] cae_data_i,
   input  logic               cae_inst_vld_i,
   output logic [`DATA_W-1:0] cae_ret_data_o,
   output logic               cae_ret_data_vld_o,
   output logic [1:0]         cae_exception_o,
   output logic               cae_idle_o,
   output logic               cae_stall_o
);

   import spmv_pkg::*;

   logic                  aeg_wr;
   logic                  aeg_rd;
   logic [`AEG_IDX_W-1:0] aeg_idx;
   logic                  idx_ok;
   logic                  launch;
   pe_word_u              aeg0;

   // chain taps, index 0 is the issued word
   pe_word_u              chain_word [`PE_COUNT+1];
   logic [`PE_COUNT:0]    chain_busy;

   // ******************************
   // host dispatch
   // ******************************
   dispatch_decode i_dispatch_decode (
      .clk             (clk),
      .reset_per       (reset_per),
      .cae_inst_i      (cae_inst_i),
      .cae_inst_vld_i  (cae_inst_vld_i),
      .aeg_wr_o        (aeg_wr),
      .aeg_rd_o        (aeg_rd),
      .aeg_idx_o       (aeg_idx),
      .idx_ok_o        (idx_ok),
      .launch_o        (launch),
      .cae_exception_o (cae_exception_o)
   );

   aeg_file i_aeg_file (
      .clk            (clk),
      .reset_per      (reset_per),
      .aeg_wr_i       (aeg_wr),
      .aeg_rd_i       (aeg_rd),
      .aeg_idx_i      (aeg_idx),
      .idx_ok_i       (idx_ok),
      .wr_data_i      (cae_data_i),
      .result_i       (chain_word[`PE_COUNT]),
      .aeg0_o         (aeg0),
      .ret_data_o     (cae_ret_data_o),
      .ret_data_vld_o (cae_ret_data_vld_o)
   );

   launch_ctrl i_launch_ctrl (
      .clk          (clk),
      .reset_per    (reset_per),
      .launch_i     (launch),
      .aeg0_i       (aeg0),
      .chain_busy_i (chain_busy[`PE_COUNT]),
      .word_o       (chain_word[0]),
      .cae_idle_o   (cae_idle_o),
      .cae_stall_o  (cae_stall_o)
   );

   // ******************************
   // stage chain
   // ******************************
   assign chain_busy[0] = 1'b0;

   for (genvar g = 0; g < `PE_COUNT; g++) begin : gen_pe
      pe_stage #(
         .PE_ID (g)
      ) i_pe_stage (
         .clk       (clk),
         .reset_per (reset_per),
         .word_i    (chain_word[g]),
         .busy_i    (chain_busy[g]),
         .word_o    (chain_word[g+1]),
         .busy_o    (chain_busy[g+1])
      );
   end

endmodule

//--- dv/spmv_pers_tb.sv
`timescale 1ns/1ps

`include "spmv_consts.svh"

module spmv_pers_tb;

   localparam int MAX_STEPS      = 64;
   localparam int IDLE_TIMEOUT   = 200;
   localparam int ACCUM_LAUNCHES = 6;
   localparam int PAY_W          = `DATA_W - `PE_ID_W - `OP_W;

   logic               clk;
   logic               reset_per;
   logic [`INST_W-1:0] cae_inst_i;
   logic [`DATA_W-1:0] cae_data_i;
   logic               cae_inst_vld_i;
   logic [`DATA_W-1:0] cae_ret_data_o;
   logic               cae_ret_data_vld_o;
   logic [1:0]         cae_exception_o;
   logic               cae_idle_o;
   logic               cae_stall_o;

   // ******************************
   // step table and reference model
   // ******************************
   logic [`INST_W-1:0] step_inst [MAX_STEPS];
   logic [`DATA_W-1:0] step_data [MAX_STEPS];
   logic [1:0]         step_exc [MAX_STEPS];
   logic               step_chk [MAX_STEPS];
   logic [`DATA_W-1:0] step_exp [MAX_STEPS];
   logic               step_launch [MAX_STEPS];
   int                 step_cnt;
   int                 cur_step;

   logic [`DATA_W-1:0] model_aeg [`AEG_CNT];
   logic [PAY_W-1:0]   model_acc [`PE_COUNT];

   spmv_pers_top i_spmv_pers_top (
      .clk                (clk),
      .reset_per          (reset_per),
      .cae_inst_i         (cae_inst_i),
      .cae_data_i         (cae_data_i),
      .cae_inst_vld_i     (cae_inst_vld_i),
      .cae_ret_data_o     (cae_ret_data_o),
      .cae_ret_data_vld_o (cae_ret_data_vld_o),
      .cae_exception_o    (cae_exception_o),
      .cae_idle_o         (cae_idle_o),
      .cae_stall_o        (cae_stall_o)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic stop_on_failure();
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [`DATA_W-1:0] got,
                              input logic [`DATA_W-1:0] exp);
      assert (got === exp) else begin
         $display("MISMATCH %s step %0d got 0x%0h expected 0x%0h", name, cur_step, got, exp);
         stop_on_failure();
      end
   endtask

   // class in the top four bits, custom number above the aeg index
   function automatic logic [`INST_W-1:0] make_inst(input logic [3:0] cls,
                                                     input logic [`CAEP_W-1:0] caep,
                                                     input logic [`AEG_IDX_W-1:0] idx);
      return {cls, {(`INST_W-4-`CAEP_W-`AEG_IDX_W){1'b0}}, caep, idx};
   endfunction

   task automatic add_step(input logic [`INST_W-1:0] inst, input logic [`DATA_W-1:0] data,
                           input logic [1:0] exc, input logic chk,
                           input logic [`DATA_W-1:0] exp, input logic launch);
      if (step_cnt >= MAX_STEPS) begin
         $display("step table is full, more than %0d steps", MAX_STEPS);
         stop_on_failure();
      end else begin
         step_inst[step_cnt]   = inst;
         step_data[step_cnt]   = data;
         step_exc[step_cnt]    = exc;
         step_chk[step_cnt]    = chk;
         step_exp[step_cnt]    = exp;
         step_launch[step_cnt] = launch;
         step_cnt++;
      end
   endtask

   task automatic aeg_write_step(input logic [`AEG_IDX_W-1:0] idx,
                                 input logic [`DATA_W-1:0] data);
      logic [1:0] exc;
      exc = 2'b00;
      if (idx < `AEG_CNT) begin
         model_aeg[int'(idx)] = data;
      end else begin
         exc = 2'b10;
      end
      add_step(make_inst(`CLASS_AEG_WR, '0, idx), data, exc, 1'b0, '0, 1'b0);
   endtask

   task automatic aeg_read_step(input logic [`AEG_IDX_W-1:0] idx);
      if (idx < `AEG_CNT) begin
         add_step(make_inst(`CLASS_AEG_RD, '0, idx), '0, 2'b00, 1'b1,
                  model_aeg[int'(idx)], 1'b0);
      end else begin
         add_step(make_inst(`CLASS_AEG_RD, '0, idx), '0, 2'b10, 1'b0, '0, 1'b0);
      end
   endtask

   // stage rules applied to the word sitting in aeg 0
   task automatic model_launch();
      logic [`OP_W-1:0]    op;
      logic [`PE_ID_W-1:0] id;
      logic [PAY_W-1:0]    pay;
      op  = model_aeg[0][`OP_W-1:0];
      id  = model_aeg[0][`OP_W +: `PE_ID_W];
      pay = model_aeg[0][`DATA_W-1 -: PAY_W];
      if (id < `PE_COUNT) begin
         if (op == `OP_ACCUM) begin
            model_acc[id] = model_acc[id] + pay;
         end else if (op == `OP_FETCH) begin
            model_aeg[0]  = {{`PE_ID_W{1'b0}}, model_acc[id], `OP_RESULT};
            model_acc[id] = '0;
         end
      end
   endtask

   task automatic custom_step(input logic [`CAEP_W-1:0] caep);
      logic [1:0] exc;
      logic       launch;
      exc    = (caep > 1) ? 2'b01 : 2'b00;
      launch = caep == 1;
      if (launch) begin
         model_launch();
      end
      add_step(make_inst(`CLASS_CUSTOM, caep, '0), '0, exc, 1'b0, '0, launch);
   endtask

   task automatic raw_step(input logic [`INST_W-1:0] inst, input logic [1:0] exc);
      add_step(inst, '0, exc, 1'b0, '0, 1'b0);
   endtask

   // sampled on the falling edge, counting from the launch cycle
   task automatic wait_for_idle(input int start_cycles);
      int cycles;
      cycles = start_cycles;
      while (!cae_idle_o && cycles < IDLE_TIMEOUT) begin
         check_value("cae_stall_o", cae_stall_o, 1);
         cycles++;
         @(negedge clk);
      end
      if (!cae_idle_o) begin
         $display("idle did not return within %0d cycles after a launch", IDLE_TIMEOUT);
         stop_on_failure();
      end else begin
         check_value("cae_stall_o", cae_stall_o, 0);
         assert (cycles == `MIN_BUSY + 2) else begin
            $display("stall lasted %0d cycles at step %0d, expected %0d",
                     cycles, cur_step, `MIN_BUSY + 2);
            stop_on_failure();
         end
      end
   endtask

   task automatic apply_step(input int s);
      cur_step = s;
      @(posedge clk);
      cae_inst_i     <= step_inst[s];
      cae_data_i     <= step_data[s];
      cae_inst_vld_i <= 1'b1;
      @(negedge clk);
      check_value("cae_stall_o", cae_stall_o, step_launch[s]);
      check_value("cae_idle_o", cae_idle_o, !step_launch[s]);
      @(posedge clk);
      cae_inst_vld_i <= 1'b0;
      cae_inst_i     <= '0;
      cae_data_i     <= '0;
      @(negedge clk);
      check_value("cae_exception_o", cae_exception_o, step_exc[s]);
      check_value("cae_ret_data_vld_o", cae_ret_data_vld_o, step_chk[s]);
      if (step_chk[s]) begin
         check_value("cae_ret_data_o", cae_ret_data_o, step_exp[s]);
      end
      check_value("cae_stall_o", cae_stall_o, step_launch[s]);
      // flags and valid last a single cycle
      @(negedge clk);
      check_value("cae_exception_o", cae_exception_o, 0);
      check_value("cae_ret_data_vld_o", cae_ret_data_vld_o, 0);
      if (step_launch[s]) begin
         wait_for_idle(2);
      end else begin
         check_value("cae_stall_o", cae_stall_o, 0);
      end
   endtask

   // ******************************
   // main sequence
   // ******************************
   initial begin
      logic [`DATA_W-1:0]  rnd;
      logic [PAY_W-1:0]    pay;
      logic [`PE_ID_W-1:0] stage_id;
      reset_per      <= 1'b1;
      cae_inst_i     <= '0;
      cae_data_i     <= '0;
      cae_inst_vld_i <= 1'b0;
      void'($urandom(32'h51e683cd));
      step_cnt = 0;
      cur_step = -1;
      stage_id = '0;
      for (int i = 0; i < `AEG_CNT; i++) begin
         model_aeg[i] = '0;
      end
      for (int i = 0; i < `PE_COUNT; i++) begin
         model_acc[i] = '0;
      end

      // register write and read back
      aeg_write_step(0, 64'h0123_4567_89ab_cdef);
      aeg_write_step(1, 64'hfedc_ba98_7654_3210);
      aeg_read_step(0);
      aeg_read_step(1);
      aeg_write_step(0, 64'h5a5a_0f0f_a5a5_f0f0);
      aeg_read_step(0);
      aeg_read_step(1);

      // out of range index
      aeg_write_step(2, 64'hdead_beef_dead_beef);
      aeg_write_step(18'h3ffff, 64'h1111_2222_3333_4444);
      aeg_read_step(2);
      aeg_read_step(0);
      aeg_read_step(1);

      // unimplemented and no-op instructions
      raw_step(make_inst(4'h0, '0, '0), 2'b01);
      raw_step(make_inst(4'hf, '0, '0), 2'b01);
      custom_step(5);
      custom_step(0);
      aeg_read_step(0);

      // accumulate into random stages, then fetch one of them twice
      for (int n = 0; n < ACCUM_LAUNCHES; n++) begin
         stage_id = 5'($urandom % `PE_COUNT);
         rnd      = {$urandom, $urandom};
         pay      = rnd[PAY_W-1:0];
         aeg_write_step(0, {pay, stage_id, `OP_ACCUM});
         custom_step(1);
      end
      aeg_write_step(0, {{PAY_W{1'b0}}, stage_id, `OP_FETCH});
      custom_step(1);
      aeg_read_step(0);
      aeg_write_step(0, {{PAY_W{1'b0}}, stage_id, `OP_FETCH});
      custom_step(1);
      aeg_read_step(0);
      aeg_read_step(1);

      repeat (8) @(posedge clk);
      reset_per <= 1'b0;
      @(negedge clk);
      check_value("cae_idle_o", cae_idle_o, 1);
      check_value("cae_stall_o", cae_stall_o, 0);
      check_value("cae_exception_o", cae_exception_o, 0);
      check_value("cae_ret_data_vld_o", cae_ret_data_vld_o, 0);

      for (int s = 0; s < step_cnt; s++) begin
         apply_step(s);
      end

      repeat (2) @(posedge clk);
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

//--- build.f
+incdir+logic
logic/spmv_pkg.sv
logic/dispatch_decode.sv
logic/launch_ctrl.sv
logic/pe_stage.sv
logic/aeg_file.sv
logic/spmv_pers_top.sv
dv/spmv_pers_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the spmv personality testbench with verilator

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
   --top-module spmv_pers_tb -o spmv_pers_sim \
   && ./obj_dir/spmv_pers_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "TEST RESULT: PASS" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
